//--- bp_pkg.sv
/* shared widths, opcodes, funct3 codes and counter constants of the branch predictor
   also holds the instruction word view used by decode and by the testbench */

package bp_pkg;

  // datapath
  localparam int unsigned xlen        = 32;                     // address and data width

  // btb geometry
  localparam int unsigned btb_entries = 64;                     // direct mapped, one way
  localparam int unsigned btb_idx_w   = $clog2(btb_entries);    // index from pc[7:2]
  localparam int unsigned btb_tag_w   = xlen - btb_idx_w - 2;   // tag from pc[31:8]

  // 2-bit saturating counter
  // 0 strong not taken, 1 weak not taken, 2 weak taken, 3 strong taken
  localparam int unsigned ctr_w       = 2;
  localparam logic [ctr_w-1:0] ctr_weak_taken = 2'd2;           // value on allocation
  localparam logic [ctr_w-1:0] ctr_taken_min  = 2'd2;           // at or above -> taken

  // major opcodes that transfer control
  localparam logic [6:0] opc_branch = 7'b1100011;               // b-type, conditional
  localparam logic [6:0] opc_jal    = 7'b1101111;               // j-type, always taken

  // branch conditions, codes 2 and 3 are not defined
  localparam logic [2:0] f3_beq  = 3'b000;                      // rs1 == rs2
  localparam logic [2:0] f3_bne  = 3'b001;                      // rs1 != rs2
  localparam logic [2:0] f3_blt  = 3'b100;                      // signed less than
  localparam logic [2:0] f3_bge  = 3'b101;                      // signed greater or equal
  localparam logic [2:0] f3_bltu = 3'b110;                      // unsigned less than
  localparam logic [2:0] f3_bgeu = 3'b111;                      // unsigned greater or equal

  // one instruction word seen as b-type or as j-type
  // both views keep the opcode in bits 6:0, fields run msb first
  typedef union packed {
    struct packed {
      logic       imm12;      // [31]    offset sign
      logic [5:0] imm10_5;    // [30:25]
      logic [4:0] rs2;        // [24:20]
      logic [4:0] rs1;        // [19:15]
      logic [2:0] funct3;     // [14:12] condition select
      logic [3:0] imm4_1;     // [11:8]
      logic       imm11;      // [7]
      logic [6:0] opcode;     // [6:0]
    } b_fmt;
    struct packed {
      logic       imm20;      // [31]    offset sign
      logic [9:0] imm10_1;    // [30:21]
      logic       imm11;      // [20]
      logic [7:0] imm19_12;   // [19:12]
      logic [4:0] rd;         // [11:7]  link register, not used here
      logic [6:0] opcode;     // [6:0]
    } j_fmt;
  } instr_u;

endpackage

//--- branch_decode.sv
/* execute-stage decode: flags conditional branches and jal, pulls out funct3
   and builds the sign-extended pc-relative offset for the resolve stage */

module branch_decode (
  input  logic                    ex_valid,   // instruction present in execute
  input  logic [31:0]             ex_instr,   // raw instruction word
  output logic                    is_branch,  // valid b-type with legal funct3
  output logic                    is_jal,     // valid jal
  output logic [2:0]              funct3,     // branch condition
  output logic [bp_pkg::xlen-1:0] offset      // sign-extended byte offset
);

  bp_pkg::instr_u         instr;              // word seen through both formats
  logic                   f3_ok;              // funct3 names a real condition
  logic                   opc_is_branch;
  logic                   opc_is_jal;
  logic [bp_pkg::xlen-1:0] b_imm;             // b-type offset
  logic [bp_pkg::xlen-1:0] j_imm;             // j-type offset

  assign instr = ex_instr;

  // codes 2 and 3 fall to default
  always_comb begin
    case (instr.b_fmt.funct3)
      bp_pkg::f3_beq,
      bp_pkg::f3_bne,
      bp_pkg::f3_blt,
      bp_pkg::f3_bge,
      bp_pkg::f3_bltu,
      bp_pkg::f3_bgeu: f3_ok = 1'b1;
      default:         f3_ok = 1'b0;
    endcase
  end

  assign opc_is_branch = (instr.b_fmt.opcode == bp_pkg::opc_branch);
  assign opc_is_jal    = (instr.j_fmt.opcode == bp_pkg::opc_jal);

  assign is_branch = ex_valid & opc_is_branch & f3_ok;   // bad funct3 is not a branch
  assign is_jal    = ex_valid & opc_is_jal;

  assign funct3 = instr.b_fmt.funct3;                    // only meaningful with is_branch

  // b-type: imm[12|10:5|4:1|11], bit 0 always zero
  assign b_imm = {{(bp_pkg::xlen-13){instr.b_fmt.imm12}},
                  instr.b_fmt.imm12,
                  instr.b_fmt.imm11,
                  instr.b_fmt.imm10_5,
                  instr.b_fmt.imm4_1,
                  1'b0};

  // j-type: imm[20|10:1|11|19:12], bit 0 always zero
  assign j_imm = {{(bp_pkg::xlen-21){instr.j_fmt.imm20}},
                  instr.j_fmt.imm20,
                  instr.j_fmt.imm19_12,
                  instr.j_fmt.imm11,
                  instr.j_fmt.imm10_1,
                  1'b0};

  // opcode picks the view, anything else gets the b-type bits
  assign offset = opc_is_jal ? j_imm : b_imm;

endmodule

//--- branch_resolve.sv
/* computes the real outcome of a control transfer in execute
   branch condition from the operands, jal always taken, target is pc plus offset */

module branch_resolve (
  input  logic                    is_branch,   // legal conditional branch
  input  logic                    is_jal,      // unconditional jump
  input  logic [2:0]              funct3,      // condition select
  input  logic [bp_pkg::xlen-1:0] offset,      // sign-extended offset
  input  logic [bp_pkg::xlen-1:0] ex_pc,       // pc of the instruction
  input  logic [bp_pkg::xlen-1:0] ex_rs1,      // first operand
  input  logic [bp_pkg::xlen-1:0] ex_rs2,      // second operand
  output logic                    act_taken,   // resolved direction
  output logic [bp_pkg::xlen-1:0] act_target   // resolved taken target
);

  logic cond;        // branch condition met
  logic eq;          // rs1 == rs2
  logic lt_s;        // signed rs1 < rs2
  logic lt_u;        // unsigned rs1 < rs2

  // shared comparators, ge forms are the inverse of lt
  assign eq   = (ex_rs1 == ex_rs2);
  assign lt_s = ($signed(ex_rs1) < $signed(ex_rs2));
  assign lt_u = (ex_rs1 < ex_rs2);

  always_comb begin
    case (funct3)
      bp_pkg::f3_beq:  cond = eq;
      bp_pkg::f3_bne:  cond = ~eq;
      bp_pkg::f3_blt:  cond = lt_s;
      bp_pkg::f3_bge:  cond = ~lt_s;
      bp_pkg::f3_bltu: cond = lt_u;
      bp_pkg::f3_bgeu: cond = ~lt_u;
      default:         cond = 1'b0;   // undefined codes never take
    endcase
  end

  // jal ignores the operands
  assign act_taken = is_jal | (is_branch & cond);

  // same adder for both formats, offset already scaled
  assign act_target = ex_pc + offset;

endmodule

//--- btb.sv
/* 64-entry direct-mapped branch target buffer
   lookup is combinational on fetch_pc, training from execute lands on the next clk_3 edge
   each entry holds valid, tag, target and a 2-bit saturating counter */

module btb (
  input  logic                    clk_3,
  input  logic                    arst_n,       // clears all valid bits
  input  logic [bp_pkg::xlen-1:0] fetch_pc,     // fetch-stage address
  output logic                    pred_taken,   // hit with counter in taken half
  output logic [bp_pkg::xlen-1:0] pred_target,  // stored target on hit, else 0
  input  logic                    upd_en,       // train this cycle
  input  logic [bp_pkg::xlen-1:0] upd_pc,       // pc of resolved instruction
  input  logic                    upd_taken,    // resolved direction
  input  logic [bp_pkg::xlen-1:0] upd_target    // resolved target
);

  // entry storage, only valid is reset
  logic [bp_pkg::btb_entries-1:0] valid_q;
  logic [bp_pkg::btb_tag_w-1:0]   tag_q [bp_pkg::btb_entries];
  logic [bp_pkg::xlen-1:0]        tgt_q [bp_pkg::btb_entries];
  logic [bp_pkg::ctr_w-1:0]       ctr_q [bp_pkg::btb_entries];

  // fetch side
  logic [bp_pkg::btb_idx_w-1:0]   fetch_idx;
  logic [bp_pkg::btb_tag_w-1:0]   fetch_tag;
  logic                           fetch_hit;

  // training side
  logic [bp_pkg::btb_idx_w-1:0]   upd_idx;
  logic [bp_pkg::btb_tag_w-1:0]   upd_tag;
  logic                           upd_hit;
  logic [bp_pkg::ctr_w-1:0]       upd_ctr;      // counter of the hit entry
  logic [bp_pkg::ctr_w-1:0]       ctr_nxt;      // counter after this outcome
  logic                           alloc;        // taken miss claims the entry

  // pc[1:0] is always zero, index sits right above it
  assign fetch_idx = fetch_pc[bp_pkg::btb_idx_w+1:2];
  assign fetch_tag = fetch_pc[bp_pkg::xlen-1:bp_pkg::btb_idx_w+2];
  assign upd_idx   = upd_pc[bp_pkg::btb_idx_w+1:2];
  assign upd_tag   = upd_pc[bp_pkg::xlen-1:bp_pkg::btb_idx_w+2];

  // lookup, same cycle as fetch_pc
  assign fetch_hit   = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);
  assign pred_taken  = fetch_hit && (ctr_q[fetch_idx] >= bp_pkg::ctr_taken_min);
  assign pred_target = fetch_hit ? tgt_q[fetch_idx] : '0;   // target even when weak nt

  // training entry match
  assign upd_hit = valid_q[upd_idx] && (tag_q[upd_idx] == upd_tag);
  assign upd_ctr = ctr_q[upd_idx];
  assign alloc   = upd_en && upd_taken && !upd_hit;         // not-taken miss is dropped

  // saturating step, up on taken and down on not taken
  always_comb begin
    ctr_nxt = upd_ctr;
    if (upd_taken) begin
      if (upd_ctr != {bp_pkg::ctr_w{1'b1}}) begin
        ctr_nxt = upd_ctr + 1'b1;                           // stops at 3
      end
    end else begin
      if (upd_ctr != '0) begin
        ctr_nxt = upd_ctr - 1'b1;                           // stops at 0
      end
    end
  end

  // valid bits, set on allocation and never cleared after reset
  always_ff @(posedge clk_3 or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (alloc) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // payload, write lands at the edge after upd_en
  always_ff @(posedge clk_3) begin
    if (upd_en && upd_hit) begin
      ctr_q[upd_idx] <= ctr_nxt;
      if (upd_taken) begin
        tgt_q[upd_idx] <= upd_target;                       // target may have moved
      end
    end else if (alloc) begin
      tag_q[upd_idx] <= upd_tag;                            // evicts any alias
      tgt_q[upd_idx] <= upd_target;
      ctr_q[upd_idx] <= bp_pkg::ctr_weak_taken;
    end
  end

endmodule

//--- redirect_unit.sv
/* checks the fetch prediction of a resolved control transfer against its outcome
   drives btb training for it and raises a one-cycle registered redirect on a miss */

module redirect_unit (
  input  logic                    clk_3,
  input  logic                    arst_n,
  input  logic                    is_branch,       // already gated by ex_valid
  input  logic                    is_jal,          // already gated by ex_valid
  input  logic [bp_pkg::xlen-1:0] ex_pc,
  input  logic                    act_taken,       // resolved direction
  input  logic [bp_pkg::xlen-1:0] act_target,      // resolved target
  input  logic                    ex_pred_taken,   // what fetch guessed
  input  logic [bp_pkg::xlen-1:0] ex_pred_target,
  output logic                    upd_en,          // btb train strobe
  output logic [bp_pkg::xlen-1:0] upd_pc,
  output logic                    upd_taken,
  output logic [bp_pkg::xlen-1:0] upd_target,
  output logic                    redirect,        // one-cycle pulse
  output logic [bp_pkg::xlen-1:0] redirect_pc      // corrected fetch address
);

  logic                    ctrl;         // control transfer in execute
  logic [bp_pkg::xlen-1:0] seq_pc;       // fall-through address
  logic [bp_pkg::xlen-1:0] act_next;     // where execution really goes
  logic [bp_pkg::xlen-1:0] pred_next;    // where fetch went
  logic                    mispredict;

  assign ctrl      = is_branch | is_jal;
  assign seq_pc    = ex_pc + 'd4;
  assign act_next  = act_taken ? act_target : seq_pc;
  assign pred_next = ex_pred_taken ? ex_pred_target : seq_pc;

  // compare full next addresses, a right guess with a wrong target still misses
  assign mispredict = ctrl && (act_next != pred_next);

  // every control transfer trains, other instructions never do
  assign upd_en     = ctrl;
  assign upd_pc     = ex_pc;
  assign upd_taken  = act_taken;
  assign upd_target = act_target;

  always_ff @(posedge clk_3 or negedge arst_n) begin
    if (!arst_n) begin
      redirect    <= 1'b0;
      redirect_pc <= '0;
    end else begin
      redirect <= mispredict;            // high for one cycle per miss
      if (mispredict) begin
        redirect_pc <= act_next;         // held until the next miss
      end
    end
  end

endmodule

//--- bp_top.sv
/* branch prediction top: btb lookup for fetch, decode and resolve in execute,
   training and redirect back to fetch, only wiring between the four blocks */

module bp_top (
  input  logic                    clk_3,
  input  logic                    arst_n,
  input  logic [bp_pkg::xlen-1:0] fetch_pc,        // fetch lookup address
  input  logic                    ex_valid,        // one cycle per execute instruction
  input  logic [bp_pkg::xlen-1:0] ex_pc,
  input  logic [31:0]             ex_instr,
  input  logic [bp_pkg::xlen-1:0] ex_rs1,
  input  logic [bp_pkg::xlen-1:0] ex_rs2,
  input  logic                    ex_pred_taken,   // prediction carried from fetch
  input  logic [bp_pkg::xlen-1:0] ex_pred_target,
  output logic                    pred_taken,
  output logic [bp_pkg::xlen-1:0] pred_target,
  output logic                    redirect,
  output logic [bp_pkg::xlen-1:0] redirect_pc
);

  // decode to resolve and redirect
  logic                    is_branch;
  logic                    is_jal;
  logic [2:0]              funct3;
  logic [bp_pkg::xlen-1:0] offset;

  // resolve to redirect
  logic                    act_taken;
  logic [bp_pkg::xlen-1:0] act_target;

  // redirect to btb training port
  logic                    upd_en;
  logic [bp_pkg::xlen-1:0] upd_pc;
  logic                    upd_taken;
  logic [bp_pkg::xlen-1:0] upd_target;

  branch_decode branch_decode_inst (
    .ex_valid  (ex_valid),
    .ex_instr  (ex_instr),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .funct3    (funct3),
    .offset    (offset)
  );

  branch_resolve branch_resolve_inst (
    .is_branch  (is_branch),
    .is_jal     (is_jal),
    .funct3     (funct3),
    .offset     (offset),
    .ex_pc      (ex_pc),
    .ex_rs1     (ex_rs1),
    .ex_rs2     (ex_rs2),
    .act_taken  (act_taken),
    .act_target (act_target)
  );

  btb btb_inst (
    .clk_3       (clk_3),
    .arst_n      (arst_n),
    .fetch_pc    (fetch_pc),
    .pred_taken  (pred_taken),
    .pred_target (pred_target),
    .upd_en      (upd_en),
    .upd_pc      (upd_pc),
    .upd_taken   (upd_taken),
    .upd_target  (upd_target)
  );

  redirect_unit redirect_unit_inst (
    .clk_3          (clk_3),
    .arst_n         (arst_n),
    .is_branch      (is_branch),
    .is_jal         (is_jal),
    .ex_pc          (ex_pc),
    .act_taken      (act_taken),
    .act_target     (act_target),
    .ex_pred_taken  (ex_pred_taken),
    .ex_pred_target (ex_pred_target),
    .upd_en         (upd_en),
    .upd_pc         (upd_pc),
    .upd_taken      (upd_taken),
    .upd_target     (upd_target),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc)
  );

endmodule

//--- bp_props.sv
/* concurrent checks on the predictor, bound into bp_top
   watches redirect timing and that taken predictions come from taken training */

module bp_props (
  input logic        clk_3,
  input logic        arst_n,
  input logic        ex_valid,
  input logic        redirect,
  input logic [31:0] fetch_pc,
  input logic        pred_taken,
  input logic        upd_en,
  input logic [31:0] upd_pc,
  input logic        upd_taken
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [63:0] trained_any;                        // index saw a taken outcome
  logic [23:0] trained_tag [64];                   // tag of the last taken outcome
  logic        fetch_trained;

  always_ff @(posedge clk_3 or negedge arst_n) begin
    if (!arst_n) begin
      trained_any <= '0;
    end else if (upd_en && upd_taken) begin
      trained_any[upd_pc[7:2]] <= 1'b1;
    end
  end

  always_ff @(posedge clk_3) begin
    if (upd_en && upd_taken) trained_tag[upd_pc[7:2]] <= upd_pc[31:8];
  end

  assign fetch_trained = trained_any[fetch_pc[7:2]] &&
                         (trained_tag[fetch_pc[7:2]] == fetch_pc[31:8]);

  assert property (@(posedge clk_3) disable iff (!arst_n) redirect |-> $past(ex_valid))
    else $error("redirect without an execute instruction in the cycle before");

  assert property (@(posedge clk_3) disable iff (!arst_n) pred_taken |-> fetch_trained)
    else $error("taken prediction for a pc never trained taken");

  assert property (@(posedge clk_3) $rose(arst_n) |-> !redirect)
    else $error("redirect high right after reset release");

endmodule

bind bp_top bp_props bp_props_inst (
  .clk_3      (clk_3),
  .arst_n     (arst_n),
  .ex_valid   (ex_valid),
  .redirect   (redirect),
  .fetch_pc   (fetch_pc),
  .pred_taken (pred_taken),
  .upd_en     (upd_en),
  .upd_pc     (upd_pc),
  .upd_taken  (upd_taken)
);

//--- bp_tb.sv
/* self-checking testbench for bp_top, seeded random branches, jals and other ops
   a reference btb model predicts lookups, training and the registered redirect */

module bp_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int sweep_cycles   = 12;              // one cold lookup per pool pc
  localparam int random_cycles  = 2000;
  localparam int timeout_cycles = 2500;            // 4 reset + sweep + random + margin

  logic        clk_3;
  logic        arst_n;
  logic [31:0] fetch_pc;
  logic        ex_valid;
  logic [31:0] ex_pc;
  logic [31:0] ex_instr;
  logic [31:0] ex_rs1;
  logic [31:0] ex_rs2;
  logic        ex_pred_taken;
  logic [31:0] ex_pred_target;
  logic        pred_taken;
  logic [31:0] pred_target;
  logic        redirect;
  logic [31:0] redirect_pc;

  integer      seed = 35280;
  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;

  // reference btb indexed by pc[7:2]
  logic        m_valid [64];
  logic [23:0] m_tag   [64];                       // pc[31:8]
  logic [31:0] m_tgt   [64];
  logic [1:0]  m_ctr   [64];

  logic        exp_redir;                          // due one cycle after ex_valid
  logic [31:0] exp_rpc;                            // held like the dut register

  // pairs with equal index and different tag force aliasing
  logic [31:0] pc_pool [12] = '{32'h0000_1000, 32'h0000_1100, 32'h0000_1004, 32'h0000_2004,
                                32'h0000_10f8, 32'h8000_00f8, 32'h0000_1010, 32'h0000_1020,
                                32'h0000_1040, 32'h0000_1080, 32'h0001_00fc, 32'h0000_1030};
  logic [12:1] slot_off [12];                      // usual offset per pool slot
  logic [6:0]  other_opc [4] = '{7'b0110011, 7'b0010011, 7'b1100111, 7'b0000011};

  bp_top bp_top_inst (
    .clk_3          (clk_3),
    .arst_n         (arst_n),
    .fetch_pc       (fetch_pc),
    .ex_valid       (ex_valid),
    .ex_pc          (ex_pc),
    .ex_instr       (ex_instr),
    .ex_rs1         (ex_rs1),
    .ex_rs2         (ex_rs2),
    .ex_pred_taken  (ex_pred_taken),
    .ex_pred_target (ex_pred_target),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc)
  );

  initial begin
    clk_3 = 1'b0;
    forever #10 clk_3 = ~clk_3;                    // 20 ns period
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s at cycle %0d: expected %h, actual %h", name, cycle_cnt, exp, act);
    end
  endtask

  // branch conditions straight from the isa rules
  function automatic logic cond_met(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
      bp_pkg::f3_beq:  return a == b;
      bp_pkg::f3_bne:  return a != b;
      bp_pkg::f3_blt:  return $signed(a) < $signed(b);
      bp_pkg::f3_bge:  return $signed(a) >= $signed(b);
      bp_pkg::f3_bltu: return a < b;
      bp_pkg::f3_bgeu: return a >= b;
      default:         return 1'b0;
    endcase
  endfunction

  task automatic model_lookup(input logic [31:0] pc, output logic tk, output logic [31:0] tg);
    logic hit;
    hit = m_valid[pc[7:2]] && (m_tag[pc[7:2]] == pc[31:8]);
    tk  = hit && (m_ctr[pc[7:2]] >= 2'd2);
    tg  = hit ? m_tgt[pc[7:2]] : 32'h0;            // zero on a miss
  endtask

  task automatic model_train(input logic [31:0] pc, input logic taken, input logic [31:0] tgt);
    logic [5:0] idx;
    logic       hit;
    idx = pc[7:2];
    hit = m_valid[idx] && (m_tag[idx] == pc[31:8]);
    if (hit && taken) begin
      if (m_ctr[idx] != 2'd3) m_ctr[idx] = m_ctr[idx] + 2'd1;
      m_tgt[idx] = tgt;
    end else if (hit) begin
      if (m_ctr[idx] != 2'd0) m_ctr[idx] = m_ctr[idx] - 2'd1;
    end else if (taken) begin                      // allocate and evict any alias
      m_valid[idx] = 1'b1;
      m_tag[idx]   = pc[31:8];
      m_tgt[idx]   = tgt;
      m_ctr[idx]   = 2'd2;
    end
  endtask

  // random branch (any funct3), jal or other opcode, with its expected outcome
  task automatic make_instr(input int slot, input logic [31:0] pc, input logic [31:0] a,
                            input logic [31:0] b, output logic [31:0] word, output logic ctrl,
                            output logic taken, output logic [31:0] target);
    bp_pkg::instr_u w;
    int             kind;
    logic [2:0]     f3;
    logic [12:1]    off;
    logic [31:0]    offs;
    kind = {$random(seed)} % 8;
    off  = ({$random(seed)} % 4 == 0) ? $random(seed) : slot_off[slot];
    offs = {{19{off[12]}}, off, 1'b0};
    w    = $random(seed);                          // random register fields
    if (kind < 4) begin
      f3 = $random(seed);
      w.b_fmt.opcode  = bp_pkg::opc_branch;
      w.b_fmt.funct3  = f3;
      w.b_fmt.imm12   = off[12];
      w.b_fmt.imm11   = off[11];
      w.b_fmt.imm10_5 = off[10:5];
      w.b_fmt.imm4_1  = off[4:1];
      ctrl  = (f3 != 3'd2) && (f3 != 3'd3);        // 2 and 3 are not branches
      taken = ctrl && cond_met(f3, a, b);
    end else if (kind < 6) begin
      w.j_fmt.opcode   = bp_pkg::opc_jal;
      w.j_fmt.imm20    = off[12];
      w.j_fmt.imm19_12 = {8{off[12]}};
      w.j_fmt.imm11    = off[11];
      w.j_fmt.imm10_1  = off[10:1];
      ctrl  = 1'b1;
      taken = 1'b1;
    end else begin
      w.b_fmt.opcode = other_opc[{$random(seed)} % 4];
      ctrl  = 1'b0;
      taken = 1'b0;
    end
    target = pc + offs;
    word   = w;
  endtask

  // one clock of checking the last redirect, driving, checking the lookup and advancing the model
  task automatic run_cycle(input logic [31:0] f_pc, input logic v, input logic [31:0] pc,
                           input logic [31:0] instr, input logic [31:0] a, input logic [31:0] b,
                           input logic ctrl, input logic taken, input logic [31:0] target);
    logic        p_tk;
    logic [31:0] p_tg;
    logic        m_tk;
    logic [31:0] m_tg;
    logic [31:0] act_nxt;
    logic [31:0] prd_nxt;
    @(posedge clk_3);
    #2;
    check_value("redirect", exp_redir, redirect);
    check_value("redirect_pc", exp_rpc, redirect_pc);
    model_lookup(pc, p_tk, p_tg);                  // what fetch would have guessed
    fetch_pc       = f_pc;
    ex_valid       = v;
    ex_pc          = pc;
    ex_instr       = instr;
    ex_rs1         = a;
    ex_rs2         = b;
    ex_pred_taken  = p_tk;
    ex_pred_target = p_tg;
    #10;                                           // mid cycle with inputs settled
    model_lookup(f_pc, m_tk, m_tg);
    check_value("pred_taken", m_tk, pred_taken);
    check_value("pred_target", m_tg, pred_target);
    act_nxt   = taken ? target : pc + 32'd4;
    prd_nxt   = p_tk ? p_tg : pc + 32'd4;
    exp_redir = v && ctrl && (act_nxt != prd_nxt);
    if (exp_redir) exp_rpc = act_nxt;
    if (v && ctrl) model_train(pc, taken, target);  // dut writes at the coming edge
  endtask

  initial begin
    int          slot;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] word;
    logic [31:0] tgt;
    logic [31:0] f_pc;
    logic [31:0] last_pc;
    logic        ctrl;
    logic        tk;
    logic        v;
    arst_n         = 1'b0;
    fetch_pc       = '0;
    ex_valid       = 1'b0;
    ex_pc          = '0;
    ex_instr       = '0;
    ex_rs1         = '0;
    ex_rs2         = '0;
    ex_pred_taken  = 1'b0;
    ex_pred_target = '0;
    exp_redir      = 1'b0;
    exp_rpc        = '0;
    last_pc        = pc_pool[0];
    for (int i = 0; i < 64; i++) begin
      m_valid[i] = 1'b0;
      m_tag[i]   = '0;
      m_tgt[i]   = '0;
      m_ctr[i]   = '0;
    end
    for (int i = 0; i < 12; i++) slot_off[i] = $random(seed);
    repeat (4) @(posedge clk_3);
    #2 arst_n = 1'b1;
    // every pool pc misses in the cold btb
    for (int i = 0; i < sweep_cycles; i++) begin
      run_cycle(pc_pool[i], 1'b0, pc_pool[0], 32'h0000_0013, '0, '0, 1'b0, 1'b0, '0);
    end
    for (int i = 0; i < random_cycles; i++) begin
      slot = {$random(seed)} % 12;
      a    = $random(seed);
      b    = ({$random(seed)} % 4 == 0) ? a : $random(seed);   // equal operands now and then
      v    = ({$random(seed)} % 8) != 0;
      f_pc = ({$random(seed)} % 4 == 0) ? last_pc : pc_pool[{$random(seed)} % 12];
      make_instr(slot, pc_pool[slot], a, b, word, ctrl, tk, tgt);
      run_cycle(f_pc, v, pc_pool[slot], word, a, b, ctrl, tk, tgt);
      last_pc = pc_pool[slot];                     // looked up again right after its write
    end
    run_cycle(pc_pool[0], 1'b0, pc_pool[0], 32'h0000_0013, '0, '0, 1'b0, 1'b0, '0);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    while (cycle_cnt < timeout_cycles) begin
      @(posedge clk_3);
      cycle_cnt++;
    end
    errors++;
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("checks %0d, errors %0d", checks, errors);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- files.f
bp_pkg.sv
branch_decode.sv
branch_resolve.sv
btb.sv
redirect_unit.sv
bp_top.sv
bp_props.sv
bp_tb.sv
